// File: flash_dump.f
flash_dump_pkg.sv
spi_flash_reader.sv
uart_tx.sv
flash_dump_seq.sv
flash_dump_top.sv
spi_flash_model.sv
tb_flash_dump.sv

// File: flash_dump_pkg.sv
package flash_dump_pkg;

   // 24-bit flash byte address as on standard serial NOR parts
   typedef logic [23:0] flash_addr_t;

   // bits 7:0 hold the lowest address of the four
   typedef logic [31:0] flash_word_t;

   typedef enum logic [7:0] {
      cmd_read = 8'h03    // plain read without dummy cycles
   } flash_cmd_t;

   typedef enum logic [1:0] {
      rd_idle,            // one cycle after reset
      rd_command,         // opcode and address going out
      rd_stream,          // words coming in
      rd_stop             // ss high until reset
   } reader_state_t;

   typedef enum logic [1:0] {
      sq_wait_word,
      sq_send_byte,
      sq_wait_busy,
      sq_finished
   } seq_state_t;

   // master output pins in mode 0
   typedef struct packed {
      logic sck;
      logic ss;
      logic mosi;
   } spi_pins_t;

endpackage

// File: flash_dump_seq.sv
module flash_dump_seq #(
   parameter int dump_words = 64
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        word_valid,
   input  flash_dump_pkg::flash_word_t word,
   output logic                        word_ack,
   output logic                        tx_start,
   output logic [7:0]                  tx_byte,
   input  logic                        tx_busy,
   output logic                        stop,
   output logic                        done
);
   import flash_dump_pkg::*;

   localparam int cnt_w = $clog2(dump_words + 1);

   seq_state_t       state;
   flash_word_t      word_q;
   logic [1:0]       byte_sel;
   logic [cnt_w-1:0] word_cnt;    // words fully sent
   logic             seen_busy;   // uart has taken the byte
   logic             byte_done;
   logic             send_now;

   assign word_ack  = (state == sq_wait_word) && word_valid;
   assign send_now  = (state == sq_send_byte) && !tx_busy;
   assign byte_done = (state == sq_wait_busy) && seen_busy && !tx_busy;
   assign stop      = (state == sq_finished);
   assign done      = (state == sq_finished);

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= sq_wait_word;
         byte_sel  <= '0;
         word_cnt  <= '0;
         seen_busy <= 1'b0;
         tx_start  <= 1'b0;
      end else begin
         tx_start <= 1'b0;
         case (state)
            sq_wait_word: begin
               if (word_valid) begin
                  byte_sel <= '0;
                  state    <= sq_send_byte;
               end
            end
            sq_send_byte: begin
               if (send_now) begin
                  tx_start  <= 1'b1;
                  seen_busy <= 1'b0;
                  state     <= sq_wait_busy;
               end
            end
            sq_wait_busy: begin
               if (tx_busy)
                  seen_busy <= 1'b1;
               if (byte_done) begin
                  byte_sel <= byte_sel + 1'b1;
                  if (byte_sel != 2'd3)
                     state <= sq_send_byte;
                  else if (word_cnt == cnt_w'(dump_words - 1))
                     state <= sq_finished;
                  else begin
                     word_cnt <= word_cnt + 1'b1;
                     state    <= sq_wait_word;
                  end
               end
            end
            default: ;    // late words are never acked
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (word_ack)
         word_q <= word;
      if (send_now)
         tx_byte <= word_q[8*byte_sel +: 8];    // low byte first
   end

endmodule

// File: flash_dump_top.sv
module flash_dump_top #(
   parameter int clk_div    = 2,
   parameter int baud_div   = 40000,
   parameter flash_dump_pkg::flash_addr_t start_addr = 24'h100000,
   parameter int dump_words = 64
) (
   input  logic                      clk,
   input  logic                      rst,
   output flash_dump_pkg::spi_pins_t spi,
   input  logic                      spi_miso,
   output logic                      uart_txd,
   output logic                      done
);
   import flash_dump_pkg::*;

   logic        word_valid;
   flash_word_t word;
   logic        word_ack;
   logic        stop;
   logic        tx_start;
   logic [7:0]  tx_byte;
   logic        tx_busy;

   spi_flash_reader #(
      .clk_div    (clk_div),
      .start_addr (start_addr)
   ) u_reader (
      .clk        (clk),
      .rst        (rst),
      .stop       (stop),
      .spi        (spi),
      .miso       (spi_miso),
      .word_valid (word_valid),
      .word       (word),
      .word_ack   (word_ack)
   );

   flash_dump_seq #(
      .dump_words (dump_words)
   ) u_seq (
      .clk        (clk),
      .rst        (rst),
      .word_valid (word_valid),
      .word       (word),
      .word_ack   (word_ack),
      .tx_start   (tx_start),
      .tx_byte    (tx_byte),
      .tx_busy    (tx_busy),
      .stop       (stop),
      .done       (done)
   );

   uart_tx #(
      .baud_div (baud_div)
   ) u_uart (
      .clk      (clk),
      .rst      (rst),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .txd      (uart_txd),
      .busy     (tx_busy)
   );

endmodule

// File: spi_flash_model.sv
module spi_flash_model #(
   parameter flash_dump_pkg::flash_addr_t start_addr = 24'h100000
) (
   input  flash_dump_pkg::spi_pins_t spi,
   output logic                      miso,
   output logic                      cmd_seen,
   output int                        cmd_errors
);
   timeunit 1ns;
   timeprecision 100ps;
   import flash_dump_pkg::*;

   logic        sck;
   logic        ss;
   logic        mosi;
   logic [31:0] cmd_sr;       // opcode and address as they arrive
   logic [31:0] exp_cmd;
   logic [7:0]  cur_byte;
   int          bit_n;
   int          data_bit;
   flash_addr_t addr;

   assign sck     = spi.sck;
   assign ss      = spi.ss;
   assign mosi    = spi.mosi;
   assign exp_cmd = {8'h03, start_addr};

   // each byte is its low address byte times 7 plus 3
   function automatic logic [7:0] byte_at(input flash_addr_t a);
      logic [7:0] lo;
      lo = a[7:0];
      return lo * 8'd7 + 8'd3;
   endfunction

   initial begin
      miso       = 1'b0;
      cmd_seen   = 1'b0;
      cmd_errors = 0;
      bit_n      = 0;
      data_bit   = 0;
      cmd_sr     = '0;
      addr       = '0;
   end

   always @(posedge sck) begin
      if (!ss && bit_n < 32) begin
         cmd_sr = {cmd_sr[30:0], mosi};
         bit_n  = bit_n + 1;
         if (bit_n % 8 == 0 && cmd_sr[7:0] !== exp_cmd[39 - bit_n -: 8]) begin
            cmd_errors = cmd_errors + 1;
            $display("ERROR: flash model got command byte %0d = %02h, expected %02h at %0t",
                     bit_n / 8 - 1, cmd_sr[7:0], exp_cmd[39 - bit_n -: 8], $time);
         end
         if (bit_n == 32) begin
            addr     = cmd_sr[23:0];
            cmd_seen = 1'b1;    // data starts on the next falling edge
            data_bit = 0;
         end
      end
   end

   always @(negedge sck) begin
      if (!ss && cmd_seen) begin
         cur_byte = byte_at(addr);
         miso     = cur_byte[7 - data_bit];    // msb first
         data_bit = data_bit + 1;
         if (data_bit == 8) begin
            data_bit = 0;
            addr     = addr + 1'b1;
         end
      end
   end

endmodule

// File: spi_flash_reader.sv
module spi_flash_reader #(
   parameter int clk_div = 2,
   parameter flash_dump_pkg::flash_addr_t start_addr = 24'h100000
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        stop,
   output flash_dump_pkg::spi_pins_t   spi,
   input  logic                        miso,
   output logic                        word_valid,
   output flash_dump_pkg::flash_word_t word,
   input  logic                        word_ack
);
   import flash_dump_pkg::*;

   localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

   reader_state_t    state;
   logic [div_w-1:0] div_cnt;
   logic             sck_q;
   logic             ss_q;
   logic [31:0]      sr;          // command out then received bits
   logic             miso_q;      // bit taken on the rising edge
   logic [4:0]       bit_cnt;
   logic             pend;        // full word waiting for the holding register
   logic             running;
   logic             tick;
   logic             rise;
   logic             fall;
   logic             last_bit;
   logic             load_word;

   assign running   = (state == rd_command || state == rd_stream) && !pend;
   assign tick      = running && (div_cnt == div_w'(clk_div - 1));
   assign rise      = tick && !sck_q;
   assign fall      = tick && sck_q;
   assign last_bit  = (bit_cnt == 5'd31);
   assign load_word = pend && !word_valid && !stop;

   always_comb begin
      spi.sck  = sck_q;
      spi.ss   = ss_q;
      spi.mosi = (state == rd_command) ? sr[31] : 1'b0;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= rd_idle;
         div_cnt    <= '0;
         sck_q      <= 1'b0;
         ss_q       <= 1'b1;
         bit_cnt    <= '0;
         pend       <= 1'b0;
         word_valid <= 1'b0;
      end else begin
         if (running && !tick)
            div_cnt <= div_cnt + 1'b1;
         else
            div_cnt <= '0;    // restart each half period

         case (state)
            rd_idle: begin
               ss_q  <= 1'b0;
               state <= rd_command;
            end
            rd_command, rd_stream: begin
               if (stop && !sck_q) begin
                  state <= rd_stop;    // sck already low so the cycle is complete
                  ss_q  <= 1'b1;
                  pend  <= 1'b0;
               end else if (rise) begin
                  sck_q <= 1'b1;
               end else if (fall) begin
                  sck_q   <= 1'b0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (last_bit && state == rd_command)
                     state <= rd_stream;
                  else if (last_bit)
                     pend <= 1'b1;      // freezes sck low
               end
            end
            default: ;                 // stays stopped until reset
         endcase

         if (word_ack)
            word_valid <= 1'b0;
         else if (load_word) begin
            word_valid <= 1'b1;
            pend       <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == rd_idle)
         sr <= {cmd_read, start_addr};
      else if (fall)
         sr <= {sr[30:0], miso_q};
      if (rise)
         miso_q <= miso;
      // the first byte of a group arrives first and sits in sr[31:24]
      if (load_word)
         word <= {sr[7:0], sr[15:8], sr[23:16], sr[31:24]};
   end

endmodule

// File: tb_flash_dump.sv
module tb_flash_dump;
   timeunit 1ns;
   timeprecision 100ps;
   import flash_dump_pkg::*;

   localparam int          clk_div        = 2;
   localparam int          baud_div       = 16;
   localparam flash_addr_t start_addr     = 24'h100000;
   localparam int          dump_words     = 16;
   localparam int          total_bytes    = dump_words * 4;
   localparam int          timeout_cycles = total_bytes * 10 * baud_div + 2000;

   logic      clk = 1'b0;
   logic      rst;
   spi_pins_t spi;
   logic      spi_miso;
   logic      uart_txd;
   logic      done;
   logic      cmd_seen;
   int        cmd_errors;

   int         mismatch_errors = 0;
   int         other_errors    = 0;
   int         byte_n          = 0;
   int         cycle_cnt       = 0;
   logic [7:0] rx_q[$];
   event       byte_rx;

   flash_dump_top #(
      .clk_div    (clk_div),
      .baud_div   (baud_div),
      .start_addr (start_addr),
      .dump_words (dump_words)
   ) dut_i (
      .clk      (clk),
      .rst      (rst),
      .spi      (spi),
      .spi_miso (spi_miso),
      .uart_txd (uart_txd),
      .done     (done)
   );

   spi_flash_model #(
      .start_addr (start_addr)
   ) flash_i (
      .spi        (spi),
      .miso       (spi_miso),
      .cmd_seen   (cmd_seen),
      .cmd_errors (cmd_errors)
   );

   always #4 clk = ~clk;

   // expected byte n of the dump per the flash content rule
   function automatic logic [7:0] ref_byte(input int n);
      flash_addr_t a;
      logic [7:0]  lo;
      a  = start_addr + flash_addr_t'(n);
      lo = a[7:0];
      return lo * 8'd7 + 8'd3;
   endfunction

   initial begin
      rst = 1'b1;
      repeat (10) @(posedge clk);
      #1 rst = 1'b0;
   end

   // idle levels through reset and just after release
   initial begin : reset_levels
      repeat (10) begin
         @(negedge clk);
         if (spi.ss !== 1'b1 || spi.sck !== 1'b0 || uart_txd !== 1'b1 || done !== 1'b0) begin
            mismatch_errors++;
            $display("MISMATCH at %0t: idle levels ss=%b sck=%b txd=%b done=%b",
                     $time, spi.ss, spi.sck, uart_txd, done);
         end
      end
   end

   initial begin : uart_decode
      logic [7:0] rx;
      int         i;
      forever begin
         @(negedge uart_txd);
         if (done === 1'b1) begin
            other_errors++;
            $display("ERROR: start bit on the UART line after done at %0t", $time);
         end
         repeat (baud_div / 2) @(negedge clk);    // middle of start bit
         if (uart_txd !== 1'b0) begin
            other_errors++;
            $display("ERROR: start bit did not stay low at %0t", $time);
         end
         for (i = 0; i < 8; i++) begin
            repeat (baud_div) @(negedge clk);
            rx[i] = uart_txd;
         end
         repeat (baud_div) @(negedge clk);
         if (uart_txd !== 1'b1) begin
            other_errors++;
            $display("ERROR: stop bit low in UART frame %0d at %0t", rx_q.size() + byte_n, $time);
         end
         rx_q.push_back(rx);
         -> byte_rx;
      end
   end

   initial begin : compare_bytes
      logic [7:0] got;
      logic [7:0] exp;
      forever begin
         @(byte_rx);
         while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (byte_n >= total_bytes) begin
               other_errors++;
               $display("ERROR: extra byte %02h received beyond the dump length at %0t",
                        got, $time);
            end else begin
               exp = ref_byte(byte_n);
               if (got !== exp) begin
                  mismatch_errors++;
                  $display("MISMATCH at %0t: byte %0d got %02h expected %02h",
                           $time, byte_n, got, exp);
               end
            end
            byte_n++;
         end
      end
   end

   initial begin : watchdog
      while (cycle_cnt < timeout_cycles) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("ERROR: timeout, the dump did not finish within %0d cycles", timeout_cycles);
      $display("errors: %0d mismatches, %0d protocol, %0d command, %0d of %0d bytes",
               mismatch_errors, other_errors, cmd_errors, byte_n, total_bytes);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : main_flow
      @(negedge rst);
      @(posedge done);
      repeat (4 * clk_div + 4) @(negedge clk);    // reader finishes its sck cycle
      if (spi.ss !== 1'b1) begin
         mismatch_errors++;
         $display("MISMATCH at %0t: ss is %b after done, expected 1", $time, spi.ss);
      end
      repeat (2 * 10 * baud_div) @(negedge clk);  // line must stay quiet
      if (done !== 1'b1) begin
         mismatch_errors++;
         $display("MISMATCH at %0t: done fell to %b before reset", $time, done);
      end
      if (cmd_seen !== 1'b1) begin
         other_errors++;
         $display("ERROR: the flash model never received a complete read command");
      end
      if (byte_n != total_bytes) begin
         other_errors++;
         $display("ERROR: received %0d bytes on the UART line, expected %0d",
                  byte_n, total_bytes);
      end
      $display("errors: %0d mismatches, %0d protocol, %0d command, %0d of %0d bytes",
               mismatch_errors, other_errors, cmd_errors, byte_n, total_bytes);
      if (mismatch_errors + other_errors + cmd_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: uart_tx.sv
module uart_tx #(
   parameter int baud_div = 16
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       tx_start,
   input  logic [7:0] tx_byte,
   output logic       txd,
   output logic       busy
);

   localparam int cnt_w = $clog2(baud_div);

   logic [cnt_w-1:0] baud_cnt;
   logic [9:0]       frame;       // stop, data, start
   logic [3:0]       bit_cnt;
   logic             bit_end;

   assign txd     = frame[0];
   assign bit_end = (baud_cnt == cnt_w'(baud_div - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         frame    <= '1;           // line idles high
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else if (!busy) begin
         if (tx_start) begin
            frame    <= {1'b1, tx_byte, 1'b0};
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
         end
      end else if (bit_end) begin
         baud_cnt <= '0;
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;          // end of stop bit with the line left high
         end else begin
            frame   <= {1'b1, frame[9:1]};
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

endmodule
